/* src.f */
hw/ooo_pkg.sv
hw/rename_stage.sv
hw/exec_unit.sv
hw/reorder_buffer.sv
hw/commit_stage.sv
hw/ooo_backend_top.sv
sim/tb_ooo_backend.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module tb_ooo_backend \
    --Mdir obj_dir

./obj_dir/Vtb_ooo_backend | tee sim.log

if grep -q "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* sim/tb_ooo_backend.sv */
`timescale 1ns/100ps

module tb_ooo_backend;

    localparam int CLK_PERIOD = 10;
    localparam int N_ALU      = 40;
    localparam int N_STORE    = 8;
    localparam int N_BRANCH   = 24;
    localparam int N_FILL     = 24;
    // four directed ops after the random mix, one add per store
    localparam int N_TOTAL    = N_ALU + 4 + 2 * N_STORE + N_BRANCH + N_FILL;
    localparam int WATCHDOG_CYCLES = N_TOTAL * ooo_pkg::MAX_LAT + 100;

    // visible retirement kinds
    localparam logic [1:0] K_NONE  = 2'd0;
    localparam logic [1:0] K_REG   = 2'd1;
    localparam logic [1:0] K_STORE = 2'd2;
    localparam logic [1:0] K_REDIR = 2'd3;

    typedef struct packed {
        logic [1:0]        kind;
        ooo_pkg::reg_idx_t rd;
        ooo_pkg::data_t    data;
        ooo_pkg::data_t    addr;
    } exp_t;

    logic              clk;
    logic              arst_n;
    logic              in_valid;
    ooo_pkg::op_t      in_op;
    ooo_pkg::reg_idx_t in_rd;
    ooo_pkg::data_t    in_a;
    ooo_pkg::data_t    in_b;
    ooo_pkg::data_t    in_imm;
    ooo_pkg::data_t    in_pc;
    logic              in_pred_taken;
    logic              in_ready;
    logic              commit_valid;
    ooo_pkg::reg_idx_t commit_rd;
    ooo_pkg::data_t    commit_data;
    logic              store_valid;
    ooo_pkg::data_t    store_addr;
    ooo_pkg::data_t    store_data;
    logic              redirect_valid;
    ooo_pkg::data_t    redirect_pc;

    // model queue holds only instructions that show up on a port
    exp_t              model_q[$];
    int                q_len;
    exp_t              retired;
    logic [1:0]        exp_kind;
    ooo_pkg::reg_idx_t exp_rd;
    ooo_pkg::data_t    exp_data;
    ooo_pkg::data_t    exp_addr;
    int                err_count;
    logic              before_first;
    ooo_pkg::data_t    next_pc;

    ooo_backend_top dut (
        .clk, .arst_n,
        .in_valid, .in_op, .in_rd, .in_a, .in_b, .in_imm, .in_pc, .in_pred_taken,
        .in_ready,
        .commit_valid, .commit_rd, .commit_data,
        .store_valid, .store_addr, .store_data,
        .redirect_valid, .redirect_pc
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, instructions stopped retiring", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic flag_mismatch(input string what);
        err_count++;
        $display("[ERROR] %0t ns: %s", $time, what);
    endtask

    // outcome of one instruction, K_NONE when nothing retires on a port
    function automatic exp_t predict(input ooo_pkg::op_t op, input ooo_pkg::reg_idx_t rd,
                                     input ooo_pkg::data_t a, input ooo_pkg::data_t b,
                                     input ooo_pkg::data_t imm, input ooo_pkg::data_t pc,
                                     input logic pred);
        exp_t e;
        logic taken;
        e = '0;
        e.rd = rd;
        taken = (a == b);
        if (op == ooo_pkg::OP_STORE) begin
            e.kind = K_STORE;
            e.addr = a + imm;
            e.data = b;
        end else if (op == ooo_pkg::OP_BEQ) begin
            if (taken != pred) begin
                e.kind = K_REDIR;
                e.addr = taken ? pc + imm : pc + 32'd4;
            end
        end else begin
            if (op == ooo_pkg::OP_ADD) e.data = a + b;
            else if (op == ooo_pkg::OP_SUB) e.data = a - b;
            else if (op == ooo_pkg::OP_XOR) e.data = a ^ b;
            else e.data = a * b;
            e.kind = (rd != '0) ? K_REG : K_NONE;
        end
        return e;
    endfunction

    function automatic ooo_pkg::op_t random_alu_op();
        case ($urandom_range(0, 3))
            0: return ooo_pkg::OP_ADD;
            1: return ooo_pkg::OP_SUB;
            2: return ooo_pkg::OP_XOR;
            default: return ooo_pkg::OP_MUL;
        endcase
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_instr(input ooo_pkg::op_t op, input ooo_pkg::reg_idx_t rd,
                              input ooo_pkg::data_t a, input ooo_pkg::data_t b,
                              input ooo_pkg::data_t imm, input logic pred);
        exp_t e;
        in_valid      = 1'b1;
        in_op         = op;
        in_rd         = rd;
        in_a          = a;
        in_b          = b;
        in_imm        = imm;
        in_pc         = next_pc;
        in_pred_taken = pred;
        // in_ready is settled by the falling edge
        while (!in_ready) @(negedge clk);
        e = predict(op, rd, a, b, imm, next_pc, pred);
        if (e.kind != K_NONE) begin
            model_q.push_back(e);
            q_len = model_q.size();
        end
        next_pc      = next_pc + 32'd4;
        before_first = 1'b0;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (q_len != 0) @(negedge clk);
    endtask

    task automatic run_alu_mix();
        ooo_pkg::reg_idx_t rd;
        for (int i = 0; i < N_ALU; i++) begin
            rd = (i % 7 == 3) ? '0 : ooo_pkg::reg_idx_t'($urandom_range(1, 31));
            send_instr(random_alu_op(), rd, $urandom(), $urandom(), '0, 1'b0);
        end
        // mul finishes after the adds behind it
        send_instr(ooo_pkg::OP_MUL, 5'd5, $urandom(), $urandom(), '0, 1'b0);
        send_instr(ooo_pkg::OP_ADD, 5'd6, $urandom(), $urandom(), '0, 1'b0);
        send_instr(ooo_pkg::OP_ADD, 5'd7, $urandom(), $urandom(), '0, 1'b0);
        send_instr(ooo_pkg::OP_ADD, 5'd8, $urandom(), $urandom(), '0, 1'b0);
    endtask

    task automatic run_stores();
        for (int i = 0; i < N_STORE; i++) begin
            send_instr(ooo_pkg::OP_STORE, ooo_pkg::reg_idx_t'($urandom_range(0, 31)),
                       $urandom(), $urandom(), ooo_pkg::data_t'($urandom_range(0, 255)), 1'b0);
            send_instr(ooo_pkg::OP_ADD, ooo_pkg::reg_idx_t'($urandom_range(1, 31)),
                       $urandom(), $urandom(), '0, 1'b0);
        end
    endtask

    task automatic run_branches();
        ooo_pkg::data_t a;
        ooo_pkg::data_t b;
        logic           eq;
        logic           pred;
        for (int i = 0; i < N_BRANCH; i++) begin
            if (i % 3 == 0) begin
                a    = $urandom();
                eq   = 1'($urandom_range(0, 1));
                b    = eq ? a : a + 32'd1;
                // alternate right and wrong guesses
                pred = (i % 6 == 0) ? eq : !eq;
                send_instr(ooo_pkg::OP_BEQ, '0, a, b,
                           ooo_pkg::data_t'($urandom_range(1, 64)) << 2, pred);
            end else begin
                send_instr(random_alu_op(), ooo_pkg::reg_idx_t'($urandom_range(1, 31)),
                           $urandom(), $urandom(), '0, 1'b0);
            end
        end
    endtask

    // back to back muls, in_valid stays high
    task automatic run_fill();
        for (int i = 0; i < N_FILL; i++) begin
            send_instr(ooo_pkg::OP_MUL, ooo_pkg::reg_idx_t'(1 + i % 31),
                       $urandom(), $urandom(), '0, 1'b0);
        end
    endtask

    // retirement pulses are stable at the falling edge
    always @(negedge clk) begin
        if (commit_valid || store_valid || redirect_valid) begin
            if (model_q.size() > 0) begin
                retired = model_q.pop_front();
            end else begin
                retired = '0;
            end
            exp_kind = retired.kind;
            exp_rd   = retired.rd;
            exp_data = retired.data;
            exp_addr = retired.addr;
            // everything younger than the branch is gone
            if (redirect_valid) begin
                model_q.delete();
            end
            q_len = model_q.size();
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
        before_first |-> in_ready && !commit_valid && !store_valid && !redirect_valid)
        else flag_mismatch("DUT not idle and ready after reset");

    a_commit_match: assert property (@(posedge clk) disable iff (!arst_n)
        commit_valid |-> exp_kind == K_REG && commit_rd == exp_rd && commit_data == exp_data)
        else flag_mismatch("register write differs from the model");

    a_store_match: assert property (@(posedge clk) disable iff (!arst_n)
        store_valid |-> exp_kind == K_STORE && store_addr == exp_addr
                        && store_data == exp_data)
        else flag_mismatch("store release differs from the model");

    a_redirect_match: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |-> exp_kind == K_REDIR && redirect_pc == exp_addr)
        else flag_mismatch("redirect differs from the model");

    a_one_retire: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({commit_valid, store_valid, redirect_valid}))
        else flag_mismatch("more than one retirement in a cycle");

    a_redirect_blocks_input: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |-> !in_ready)
        else flag_mismatch("input accepted during a redirect");

    // q_len already counts the instruction being accepted
    a_depth_limit: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && in_ready |-> q_len <= ooo_pkg::ROB_DEPTH)
        else flag_mismatch("input accepted with the reorder buffer full");

    initial begin
        void'($urandom(77463));
        err_count     = 0;
        q_len         = 0;
        before_first  = 1'b0;
        next_pc       = 32'h0000_1000;
        exp_kind      = K_NONE;
        exp_rd        = '0;
        exp_data      = '0;
        exp_addr      = '0;
        arst_n        = 1'b0;
        in_valid      = 1'b0;
        in_op         = ooo_pkg::OP_ADD;
        in_rd         = '0;
        in_a          = '0;
        in_b          = '0;
        in_imm        = '0;
        in_pc         = '0;
        in_pred_taken = 1'b0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        before_first = 1'b1;
        repeat (3) @(negedge clk);

        run_alu_mix();
        wait_drained();
        run_stores();
        wait_drained();
        run_branches();
        wait_drained();
        run_fill();
        wait_drained();
        // a late or duplicated pulse finds no model entry here
        repeat (10) @(negedge clk);

        $display("run complete, %0d errors", err_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* hw/ooo_backend_top.sv */
`timescale 1ns/100ps

module ooo_backend_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  ooo_pkg::op_t      in_op,
    input  ooo_pkg::reg_idx_t in_rd,
    input  ooo_pkg::data_t    in_a,
    input  ooo_pkg::data_t    in_b,
    input  ooo_pkg::data_t    in_imm,
    input  ooo_pkg::data_t    in_pc,
    input  logic              in_pred_taken,
    output logic              in_ready,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::data_t    commit_data,
    output logic              store_valid,
    output ooo_pkg::data_t    store_addr,
    output ooo_pkg::data_t    store_data,
    output logic              redirect_valid,
    output ooo_pkg::data_t    redirect_pc
);

    // allocation
    logic              alloc_valid;
    ooo_pkg::op_t      alloc_op;
    ooo_pkg::reg_idx_t alloc_rd;
    logic              alloc_pred_taken;
    ooo_pkg::data_t    alloc_pc;
    logic              full;
    ooo_pkg::tag_t     tail_tag;

    // issue
    logic           iss_valid;
    logic           iss_ready;
    ooo_pkg::tag_t  iss_tag;
    ooo_pkg::op_t   iss_op;
    ooo_pkg::data_t iss_a;
    ooo_pkg::data_t iss_b;
    ooo_pkg::data_t iss_imm;
    ooo_pkg::data_t iss_pc;

    // results
    logic           res_valid;
    ooo_pkg::tag_t  res_tag;
    ooo_pkg::data_t res_data;
    logic           res_taken;
    ooo_pkg::data_t res_target;

    // head and flush
    logic              head_valid;
    logic              head_pop;
    ooo_pkg::op_t      head_op;
    ooo_pkg::reg_idx_t head_rd;
    ooo_pkg::data_t    head_data;
    logic              head_taken;
    logic              head_pred_taken;
    ooo_pkg::data_t    head_target;
    ooo_pkg::data_t    head_pc;
    logic              flush;

    rename_stage u_rename (
        .clk, .arst_n,
        .in_valid, .in_op, .in_rd, .in_a, .in_b, .in_imm, .in_pc, .in_pred_taken,
        .full, .tail_tag, .iss_ready, .flush, .in_ready,
        .alloc_valid, .alloc_op, .alloc_rd, .alloc_pred_taken, .alloc_pc,
        .iss_valid, .iss_tag, .iss_op, .iss_a, .iss_b, .iss_imm, .iss_pc
    );

    exec_unit u_exec (
        .clk, .arst_n,
        .iss_valid, .iss_tag, .iss_op, .iss_a, .iss_b, .iss_imm, .iss_pc,
        .flush, .iss_ready,
        .res_valid, .res_tag, .res_data, .res_taken, .res_target
    );

    reorder_buffer u_rob (
        .clk, .arst_n,
        .alloc_valid, .alloc_op, .alloc_rd, .alloc_pred_taken, .alloc_pc,
        .res_valid, .res_tag, .res_data, .res_taken, .res_target,
        .head_pop, .flush, .full, .tail_tag,
        .head_valid, .head_op, .head_rd, .head_data, .head_taken,
        .head_pred_taken, .head_target, .head_pc
    );

    commit_stage u_commit (
        .clk, .arst_n,
        .head_valid, .head_op, .head_rd, .head_data, .head_taken,
        .head_pred_taken, .head_target, .head_pc,
        .head_pop, .flush,
        .commit_valid, .commit_rd, .commit_data,
        .store_valid, .store_addr, .store_data,
        .redirect_valid, .redirect_pc
    );

endmodule

/* hw/commit_stage.sv */
`timescale 1ns/100ps

module commit_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              head_valid,
    input  ooo_pkg::op_t      head_op,
    input  ooo_pkg::reg_idx_t head_rd,
    input  ooo_pkg::data_t    head_data,
    input  logic              head_taken,
    input  logic              head_pred_taken,
    input  ooo_pkg::data_t    head_target,
    input  ooo_pkg::data_t    head_pc,
    output logic              head_pop,
    output logic              flush,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::data_t    commit_data,
    output logic              store_valid,
    output ooo_pkg::data_t    store_addr,
    output ooo_pkg::data_t    store_data,
    output logic              redirect_valid,
    output ooo_pkg::data_t    redirect_pc
);

    logic is_store;
    logic is_branch;
    logic mispredict;

    assign is_store   = (head_op == ooo_pkg::OP_STORE);
    assign is_branch  = (head_op == ooo_pkg::OP_BEQ);
    assign mispredict = is_branch && (head_taken != head_pred_taken);

    // nothing retires while the flush is going out
    assign head_pop = head_valid && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid   <= 1'b0;
            store_valid    <= 1'b0;
            redirect_valid <= 1'b0;
            flush          <= 1'b0;
        end else begin
            commit_valid   <= head_pop && !is_store && !is_branch && (head_rd != '0);
            store_valid    <= head_pop && is_store;
            redirect_valid <= head_pop && mispredict;
            flush          <= head_pop && mispredict;
        end
    end

    always_ff @(posedge clk) begin
        commit_rd   <= head_rd;
        commit_data <= head_data;
        store_addr  <= head_target;
        store_data  <= head_data;
        // fetch resumes on the path the branch really took
        redirect_pc <= head_taken ? head_target
                                  : head_pc + ooo_pkg::data_t'(ooo_pkg::BRANCH_STEP);
    end

endmodule

/* hw/reorder_buffer.sv */
`timescale 1ns/100ps

module reorder_buffer (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              alloc_valid,
    input  ooo_pkg::op_t      alloc_op,
    input  ooo_pkg::reg_idx_t alloc_rd,
    input  logic              alloc_pred_taken,
    input  ooo_pkg::data_t    alloc_pc,
    input  logic              res_valid,
    input  ooo_pkg::tag_t     res_tag,
    input  ooo_pkg::data_t    res_data,
    input  logic              res_taken,
    input  ooo_pkg::data_t    res_target,
    input  logic              head_pop,
    input  logic              flush,
    output logic              full,
    output ooo_pkg::tag_t     tail_tag,
    output logic              head_valid,
    output ooo_pkg::op_t      head_op,
    output ooo_pkg::reg_idx_t head_rd,
    output ooo_pkg::data_t    head_data,
    output logic              head_taken,
    output logic              head_pred_taken,
    output ooo_pkg::data_t    head_target,
    output ooo_pkg::data_t    head_pc
);

    localparam int DEPTH = ooo_pkg::ROB_DEPTH;

    // per-entry flags
    logic [DEPTH-1:0] busy;
    logic [DEPTH-1:0] done;

    // filled at allocation
    ooo_pkg::op_t      ent_op         [DEPTH];
    ooo_pkg::reg_idx_t ent_rd         [DEPTH];
    logic              ent_pred_taken [DEPTH];
    ooo_pkg::data_t    ent_pc         [DEPTH];

    // filled at completion
    ooo_pkg::data_t ent_data   [DEPTH];
    logic           ent_taken  [DEPTH];
    ooo_pkg::data_t ent_target [DEPTH];

    ooo_pkg::tag_t             head_ptr;
    ooo_pkg::tag_t             tail_ptr;
    logic [ooo_pkg::TAG_W:0]   count;

    assign full     = (count == ooo_pkg::TAG_W'(0) + DEPTH);
    assign tail_tag = tail_ptr;

    // oldest entry, offered once its result is in
    assign head_valid      = busy[head_ptr] && done[head_ptr];
    assign head_op         = ent_op[head_ptr];
    assign head_rd         = ent_rd[head_ptr];
    assign head_data       = ent_data[head_ptr];
    assign head_taken      = ent_taken[head_ptr];
    assign head_pred_taken = ent_pred_taken[head_ptr];
    assign head_target     = ent_target[head_ptr];
    assign head_pc         = ent_pc[head_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= '0;
            done     <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush) begin
            // mispredict drops everything still in flight
            busy     <= '0;
            done     <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (head_pop) begin
                busy[head_ptr] <= 1'b0;
                done[head_ptr] <= 1'b0;
                head_ptr       <= head_ptr + 1'b1;
            end
            if (res_valid) begin
                done[res_tag] <= 1'b1;
            end
            if (alloc_valid) begin
                busy[tail_ptr] <= 1'b1;
                done[tail_ptr] <= 1'b0;
                tail_ptr       <= tail_ptr + 1'b1;
            end
            count <= count + (alloc_valid ? 1'b1 : 1'b0) - (head_pop ? 1'b1 : 1'b0);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            ent_op[tail_ptr]         <= alloc_op;
            ent_rd[tail_ptr]         <= alloc_rd;
            ent_pred_taken[tail_ptr] <= alloc_pred_taken;
            ent_pc[tail_ptr]         <= alloc_pc;
        end
        if (res_valid) begin
            ent_data[res_tag]   <= res_data;
            ent_taken[res_tag]  <= res_taken;
            ent_target[res_tag] <= res_target;
        end
    end

    // exec only returns tags that rename handed out
    a_res_to_busy: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid |-> busy[res_tag] && !done[res_tag]);

    a_pop_needs_head: assert property (@(posedge clk) disable iff (!arst_n)
        head_pop |-> head_valid);

endmodule

/* hw/exec_unit.sv */
`timescale 1ns/100ps

module exec_unit (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           iss_valid,
    input  ooo_pkg::tag_t  iss_tag,
    input  ooo_pkg::op_t   iss_op,
    input  ooo_pkg::data_t iss_a,
    input  ooo_pkg::data_t iss_b,
    input  ooo_pkg::data_t iss_imm,
    input  ooo_pkg::data_t iss_pc,
    input  logic           flush,
    output logic           iss_ready,
    output logic           res_valid,
    output ooo_pkg::tag_t  res_tag,
    output ooo_pkg::data_t res_data,
    output logic           res_taken,
    output ooo_pkg::data_t res_target
);

    localparam int NSLOT = ooo_pkg::MAX_LAT;

    // slot 0 drives the result port, higher slots are further away
    logic [NSLOT-1:0] slot_valid;
    logic [NSLOT-1:0] shifted_valid;
    ooo_pkg::tag_t    slot_tag    [NSLOT];
    ooo_pkg::data_t   slot_data   [NSLOT];
    logic             slot_taken  [NSLOT];
    ooo_pkg::data_t   slot_target [NSLOT];

    logic [1:0]     iss_lat;
    logic           iss_fire;
    ooo_pkg::data_t calc_data;
    logic           calc_taken;
    ooo_pkg::data_t calc_target;

    // occupancy after this cycle's shift
    assign shifted_valid = {1'b0, slot_valid[NSLOT-1:1]};

    always_comb begin
        case (iss_op)
            ooo_pkg::OP_MUL:   iss_lat = 2'(ooo_pkg::LAT_MUL);
            ooo_pkg::OP_STORE: iss_lat = 2'(ooo_pkg::LAT_STORE);
            default:           iss_lat = 2'(ooo_pkg::LAT_ALU);
        endcase
    end

    assign iss_ready = !shifted_valid[iss_lat-1];
    assign iss_fire  = iss_valid && iss_ready;

    // whole result computed at issue, the slot only delays it
    always_comb begin
        calc_data   = '0;
        calc_taken  = 1'b0;
        calc_target = '0;
        case (iss_op)
            ooo_pkg::OP_ADD: calc_data = iss_a + iss_b;
            ooo_pkg::OP_SUB: calc_data = iss_a - iss_b;
            ooo_pkg::OP_XOR: calc_data = iss_a ^ iss_b;
            ooo_pkg::OP_MUL: calc_data = iss_a * iss_b;
            ooo_pkg::OP_BEQ: begin
                calc_taken  = (iss_a == iss_b);
                calc_target = iss_pc + iss_imm;
            end
            ooo_pkg::OP_STORE: begin
                // store data and address
                calc_data   = iss_b;
                calc_target = iss_a + iss_imm;
            end
            default: calc_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_valid <= '0;
        end else if (flush) begin
            slot_valid <= '0;
        end else begin
            slot_valid <= shifted_valid;
            if (iss_fire) begin
                slot_valid[iss_lat-1] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NSLOT - 1; i++) begin
            slot_tag[i]    <= slot_tag[i+1];
            slot_data[i]   <= slot_data[i+1];
            slot_taken[i]  <= slot_taken[i+1];
            slot_target[i] <= slot_target[i+1];
        end
        if (iss_fire) begin
            slot_tag[iss_lat-1]    <= iss_tag;
            slot_data[iss_lat-1]   <= calc_data;
            slot_taken[iss_lat-1]  <= calc_taken;
            slot_target[iss_lat-1] <= calc_target;
        end
    end

    assign res_valid  = slot_valid[0];
    assign res_tag    = slot_tag[0];
    assign res_data   = slot_data[0];
    assign res_taken  = slot_taken[0];
    assign res_target = slot_target[0];

    // an issued op comes out untouched after its latency, so no slot was overwritten
    for (genvar l = 1; l <= NSLOT; l++) begin : g_lat_chk
        a_slot_kept: assert property (@(posedge clk) disable iff (!arst_n || flush)
            iss_fire && iss_lat == l |-> ##l (res_valid && res_tag == $past(iss_tag, l)));
    end

endmodule

/* hw/rename_stage.sv */
`timescale 1ns/100ps

module rename_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  ooo_pkg::op_t      in_op,
    input  ooo_pkg::reg_idx_t in_rd,
    input  ooo_pkg::data_t    in_a,
    input  ooo_pkg::data_t    in_b,
    input  ooo_pkg::data_t    in_imm,
    input  ooo_pkg::data_t    in_pc,
    input  logic              in_pred_taken,
    input  logic              full,
    input  ooo_pkg::tag_t     tail_tag,
    input  logic              iss_ready,
    input  logic              flush,
    output logic              in_ready,
    output logic              alloc_valid,
    output ooo_pkg::op_t      alloc_op,
    output ooo_pkg::reg_idx_t alloc_rd,
    output logic              alloc_pred_taken,
    output ooo_pkg::data_t    alloc_pc,
    output logic              iss_valid,
    output ooo_pkg::tag_t     iss_tag,
    output ooo_pkg::op_t      iss_op,
    output ooo_pkg::data_t    iss_a,
    output ooo_pkg::data_t    iss_b,
    output ooo_pkg::data_t    iss_imm,
    output ooo_pkg::data_t    iss_pc
);

    // keeps in_ready low until the first cycle out of reset
    logic started;
    logic accept;

    // issue register is free if empty or draining into exec this cycle
    assign in_ready = started && !full && !flush && (!iss_valid || iss_ready);
    assign accept   = in_valid && in_ready;

    // allocation goes straight to the tail of the buffer
    assign alloc_valid      = accept;
    assign alloc_op         = in_op;
    assign alloc_rd         = in_rd;
    assign alloc_pred_taken = in_pred_taken;
    assign alloc_pc         = in_pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started   <= 1'b0;
            iss_valid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (flush) begin
                iss_valid <= 1'b0;
            end else if (accept) begin
                iss_valid <= 1'b1;
            end else if (iss_ready) begin
                iss_valid <= 1'b0;
            end
        end
    end

    // operands and the tag the buffer handed out
    always_ff @(posedge clk) begin
        if (accept) begin
            iss_tag <= tail_tag;
            iss_op  <= in_op;
            iss_a   <= in_a;
            iss_b   <= in_b;
            iss_imm <= in_imm;
            iss_pc  <= in_pc;
        end
    end

    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        alloc_valid |-> !full);

endmodule

/* hw/ooo_pkg.sv */
package ooo_pkg;

    // basic widths
    localparam int DATA_W = 32;
    localparam int REG_W  = 5;
    localparam int TAG_W  = 3;
    localparam int OP_W   = 3;

    typedef logic [DATA_W-1:0] data_t;
    // register 0 means no write
    typedef logic [REG_W-1:0]  reg_idx_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [OP_W-1:0]   op_t;

    // opcodes
    localparam op_t OP_ADD   = 3'd0;
    localparam op_t OP_SUB   = 3'd1;
    localparam op_t OP_XOR   = 3'd2;
    localparam op_t OP_MUL   = 3'd3;
    localparam op_t OP_BEQ   = 3'd4;
    localparam op_t OP_STORE = 3'd5;

    // one entry per tag value
    localparam int ROB_DEPTH = 1 << TAG_W;

    // execution latencies in cycles
    localparam int LAT_ALU   = 1;
    localparam int LAT_STORE = 2;
    localparam int LAT_MUL   = 3;
    localparam int MAX_LAT   = 3;

    // fall-through step of a not-taken branch
    localparam int BRANCH_STEP = 4;

endpackage
